// ==== list.f ====
source/audioPkg.sv
source/pcmBusRegs.sv
source/pcmSampleMemory.sv
source/pcmSamplePlayer.sv
source/pcmMixer.sv
source/deltaSigmaPwm.sv
source/pcmAudioDevice.sv
test/pcmAudioDeviceTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PCM sound device testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -f list.f --top-module pcmAudioDeviceTb -o simPcm; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/simPcm > sim.log 2>&1; then
	cat sim.log
	echo "simulation returned an error"
	exit 1
fi

cat sim.log

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/audioPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants of the PCM sound device
// address map, widths, rate table, bus response codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package audioPkg;

	// address map, device at xx09_xxxx
	localparam logic [11:0] deviceSelect = 12'h009;
	localparam logic [3:0] controlPage = 4'hF;

	// register word indices, address bits 7..2
	localparam logic [5:0] regCtrl0Index = 6'd0;
	localparam logic [5:0] regCtrl1Index = 6'd1;
	localparam logic [5:0] regPositionIndex = 6'd8;

	// sample memory, 64-bit blocks
	localparam int memDepth = 1024;
	localparam int memIndexWidth = 10;

	localparam int samplePosWidth = 13;
	localparam int sampleWidth = 12;
	localparam int levelWidth = 16;
	localparam int divWidth = 14;

	// sample period reloads for a 50 MHz clock
	localparam logic [divWidth-1:0] rateReload [0:15] = '{
		14'd6250, 14'd4535, 14'd3125, 14'd2268,
		14'd1562, 14'd1134, 14'd781, 14'd567,
		14'd390, 14'd1042, 14'd390, 14'd521,
		14'd390, 14'd390, 14'd390, 14'd390
	};

	typedef enum logic [1:0]
	{
		respReady = 2'b00,
		respOk = 2'b01
	} busResp;

	// bit positions in the 5-bit bus operation code
	localparam int opmReadBit = 3;
	localparam int opmWriteBit = 4;

	// ctrl0 field positions
	localparam int ctrlCompandBit = 0;
	localparam int ctrl16BitBit = 1;
	localparam int ctrlEnableBit = 3;
	localparam int ctrlRateLsb = 4;

	// beeper square wave levels
	localparam logic [levelWidth-1:0] beepHigh = 16'h0FFF;
	localparam logic [levelWidth-1:0] beepLow = 16'hF000;

endpackage

// ==== source/deltaSigmaPwm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first-order delta-sigma and output delay line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module deltaSigmaPwm
(
	input logic clock,
	input logic reset,
	input logic outEnable,
	input logic [audioPkg::levelWidth-1:0] pwmLevel,
	output logic [1:0] pwmOut,
	output logic pwmEna
);
	import audioPkg::*;

	logic [levelWidth-1:0] accum;
	logic [levelWidth-1:0] accumNext;
	logic carry;
	logic [1:0] outBits;
	// enable and both output bits per stage
	logic [2:0] stage [4];

	assign {carry, accumNext} = {1'b0, accum} + {1'b0, pwmLevel};
	assign outBits = outEnable ? {carry, carry} : 2'b11;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			accum <= '0;
			for (int i = 0; i < 4; i++)
				stage[i] <= 3'b011;
		end
		else
		begin
			accum <= accumNext;
			stage[0] <= {outEnable, outBits};
			for (int i = 1; i < 4; i++)
				stage[i] <= stage[i-1];
		end
	end

	assign pwmEna = stage[3][2];
	assign pwmOut = stage[3][1:0];

	// mono output drives both pins alike
	assert property (@(posedge clock) disable iff (reset) pwmOut[0] == pwmOut[1]);

endmodule

// ==== source/pcmAudioDevice.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the mono PCM sound device
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmAudioDevice
(
	input logic clock,
	input logic reset,
	input logic [31:0] busAddr,
	input logic [31:0] busInData,
	input logic [4:0] busOpm,
	output logic [31:0] busOutData,
	output audioPkg::busResp busOK,
	input logic tick1MHz,
	output logic [1:0] pwmOut,
	output logic pwmEna
);
	import audioPkg::*;

	logic [samplePosWidth-1:0] samplePos;
	logic memWrite;
	logic [memIndexWidth-1:0] memIndex;
	logic memBank;
	logic [31:0] memData;
	logic useCompand;
	logic use16Bit;
	logic outEnable;
	logic [3:0] rateSelect;
	logic [15:0] beepReload;
	logic [memIndexWidth-1:0] blockIndex;
	logic [63:0] block;
	logic [sampleWidth-1:0] sample;
	logic [levelWidth-1:0] pwmLevel;

	pcmBusRegs pcmBusRegs_i
	(
		.clock(clock),
		.reset(reset),
		.busAddr(busAddr),
		.busInData(busInData),
		.busOpm(busOpm),
		.busOutData(busOutData),
		.busOK(busOK),
		.samplePos(samplePos),
		.memWrite(memWrite),
		.memIndex(memIndex),
		.memBank(memBank),
		.memData(memData),
		.useCompand(useCompand),
		.use16Bit(use16Bit),
		.outEnable(outEnable),
		.rateSelect(rateSelect),
		.beepReload(beepReload)
	);

	pcmSampleMemory pcmSampleMemory_i
	(
		.clock(clock),
		.memWrite(memWrite),
		.memIndex(memIndex),
		.memBank(memBank),
		.memData(memData),
		.blockIndex(blockIndex),
		.block(block)
	);

	pcmSamplePlayer pcmSamplePlayer_i
	(
		.clock(clock),
		.reset(reset),
		.useCompand(useCompand),
		.use16Bit(use16Bit),
		.rateSelect(rateSelect),
		.block(block),
		.blockIndex(blockIndex),
		.samplePos(samplePos),
		.sample(sample)
	);

	pcmMixer pcmMixer_i
	(
		.clock(clock),
		.reset(reset),
		.tick1MHz(tick1MHz),
		.sample(sample),
		.beepReload(beepReload),
		.pwmLevel(pwmLevel)
	);

	deltaSigmaPwm deltaSigmaPwm_i
	(
		.clock(clock),
		.reset(reset),
		.outEnable(outEnable),
		.pwmLevel(pwmLevel),
		.pwmOut(pwmOut),
		.pwmEna(pwmEna)
	);

endmodule

// ==== source/pcmBusRegs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus request register, decode and control registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmBusRegs
(
	input logic clock,
	input logic reset,
	input logic [31:0] busAddr,
	input logic [31:0] busInData,
	input logic [4:0] busOpm,
	output logic [31:0] busOutData,
	output audioPkg::busResp busOK,
	input logic [audioPkg::samplePosWidth-1:0] samplePos,
	output logic memWrite,
	output logic [audioPkg::memIndexWidth-1:0] memIndex,
	output logic memBank,
	output logic [31:0] memData,
	output logic useCompand,
	output logic use16Bit,
	output logic outEnable,
	output logic [3:0] rateSelect,
	output logic [15:0] beepReload
);
	import audioPkg::*;

	logic [31:0] reqAddr;
	logic [31:0] reqInData;
	logic [4:0] reqOpm;
	logic [31:0] ctrl0;
	logic [31:0] ctrl1;
	logic devSelected;
	logic ctrlSelected;
	logic memSelected;
	logic isRead;
	logic isWrite;
	logic [5:0] regIndex;
	logic [31:0] readData;

	// request is taken in one cycle before decoding
	always_ff @(posedge clock)
	begin
		reqAddr <= busAddr;
		reqInData <= busInData;
		if (reset)
			reqOpm <= '0;
		else
			reqOpm <= busOpm;
	end

	assign devSelected = (reqAddr[27:16] == deviceSelect);
	assign ctrlSelected = (reqAddr[15:12] == controlPage);
	assign memSelected = (reqAddr[15:14] == 2'b00);
	assign isRead = devSelected && reqOpm[opmReadBit];
	assign isWrite = devSelected && reqOpm[opmWriteBit];
	assign regIndex = reqAddr[7:2];

	// 64-bit block, address bit 2 picks the half
	assign memWrite = isWrite && memSelected;
	assign memIndex = reqAddr[12:3];
	assign memBank = reqAddr[2];
	assign memData = reqInData;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrl0 <= '0;
			ctrl1 <= '0;
		end
		else if (isWrite && ctrlSelected)
		begin
			if (regIndex == regCtrl0Index)
				ctrl0 <= reqInData;
			if (regIndex == regCtrl1Index)
				ctrl1 <= reqInData;
		end
	end

	always_comb
	begin
		readData = '0;
		if (isRead && ctrlSelected)
		begin
			case (regIndex)
				regCtrl0Index: readData = ctrl0;
				regCtrl1Index: readData = ctrl1;
				regPositionIndex: readData = {{(32 - samplePosWidth){1'b0}}, samplePos};
				default: readData = '0;
			endcase
		end
	end

	// response lands two cycles after the request
	always_ff @(posedge clock)
	begin
		busOutData <= readData;
		if (reset)
			busOK <= respReady;
		else if (isRead || isWrite)
			busOK <= respOk;
		else
			busOK <= respReady;
	end

	assign useCompand = ctrl0[ctrlCompandBit];
	assign use16Bit = ctrl0[ctrl16BitBit];
	assign outEnable = ctrl0[ctrlEnableBit];
	assign rateSelect = ctrl0[ctrlRateLsb +: 4];
	assign beepReload = ctrl1[15:0];

	// a memory write traces back to a selected write on the bus
	assert property (@(posedge clock) disable iff (reset)
		memWrite |-> $past(busAddr[27:16] == deviceSelect && busOpm[opmWriteBit]));

endmodule

// ==== source/pcmMixer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beeper, level scaling and saturation to PWM level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmMixer
(
	input logic clock,
	input logic reset,
	input logic tick1MHz,
	input logic [audioPkg::sampleWidth-1:0] sample,
	input logic [15:0] beepReload,
	output logic [audioPkg::levelWidth-1:0] pwmLevel
);
	import audioPkg::*;

	logic tickReg;
	logic [15:0] beepReload1;
	logic [15:0] beepReload2;
	logic beepEna1;
	logic beepEna2;
	logic [15:0] beepCount;
	logic beepBit;
	logic [levelWidth-1:0] pcmVal;
	logic [levelWidth-1:0] mixVal;
	logic [levelWidth-1:0] mixSum;

	// beeper setup through two delay stages
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tickReg <= 1'b0;
			beepReload1 <= '0;
			beepReload2 <= '0;
			beepEna1 <= 1'b0;
			beepEna2 <= 1'b0;
			beepCount <= '0;
			beepBit <= 1'b0;
		end
		else
		begin
			tickReg <= tick1MHz;
			beepReload1 <= beepReload;
			beepReload2 <= beepReload1;
			beepEna1 <= (beepReload != '0);
			beepEna2 <= beepEna1;
			if (tickReg)
			begin
				if (beepCount == '0)
				begin
					beepCount <= beepReload2;
					beepBit <= ~beepBit;
				end
				else
					beepCount <= beepCount - 1'b1;
			end
		end
	end

	// widen by repeating the top nibble
	always_ff @(posedge clock)
	begin
		pcmVal <= {sample, sample[sampleWidth-1 -: 4]};
		mixSum <= mixVal;
	end

	always_comb
	begin
		mixVal = {{2{pcmVal[levelWidth-1]}}, pcmVal[levelWidth-1:2]};
		if (beepEna2)
			mixVal = beepBit ? beepHigh : beepLow;
	end

	// signed sum to unsigned level, clipped outside +-8K
	always_comb
	begin
		case (mixSum[15:13])
			3'b000: pwmLevel = {1'b1, mixSum[12:0], 2'b00};
			3'b111: pwmLevel = {1'b0, mixSum[12:0], 2'b00};
			3'b001, 3'b010, 3'b011: pwmLevel = '1;
			default: pwmLevel = '0;
		endcase
	end

endmodule

// ==== source/pcmSampleMemory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample memory, two 32-bit banks read as one block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmSampleMemory
(
	input logic clock,
	input logic memWrite,
	input logic [audioPkg::memIndexWidth-1:0] memIndex,
	input logic memBank,
	input logic [31:0] memData,
	input logic [audioPkg::memIndexWidth-1:0] blockIndex,
	output logic [63:0] block
);
	import audioPkg::*;

	// bank 0 is the lower word of each block
	logic [31:0] bank0 [memDepth];
	logic [31:0] bank1 [memDepth];

	always_ff @(posedge clock)
	begin
		if (memWrite)
		begin
			if (memBank)
				bank1[memIndex] <= memData;
			else
				bank0[memIndex] <= memData;
		end
	end

	// player side, one cycle read
	always_ff @(posedge clock)
	begin
		block <= {bank1[blockIndex], bank0[blockIndex]};
	end

endmodule

// ==== source/pcmSamplePlayer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample rate divider, position and format decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmSamplePlayer
(
	input logic clock,
	input logic reset,
	input logic useCompand,
	input logic use16Bit,
	input logic [3:0] rateSelect,
	input logic [63:0] block,
	output logic [audioPkg::memIndexWidth-1:0] blockIndex,
	output logic [audioPkg::samplePosWidth-1:0] samplePos,
	output logic [audioPkg::sampleWidth-1:0] sample
);
	import audioPkg::*;

	logic [divWidth-1:0] divReload;
	logic [divWidth-1:0] divCount;
	logic [7:0] byteSel;
	logic [15:0] halfSel;
	logic [2:0] exponent;
	logic [3:0] mantissa;
	logic [10:0] magnitude;
	logic [sampleWidth-1:0] companded;

	// rate lookup is registered, hence one cycle late
	always_ff @(posedge clock)
	begin
		if (reset)
			divReload <= rateReload[0];
		else
			divReload <= rateReload[rateSelect];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			divCount <= '0;
			samplePos <= '0;
		end
		else if (divCount == '0)
		begin
			divCount <= divReload;
			samplePos <= samplePos + 1'b1;
		end
		else
			divCount <= divCount - 1'b1;
	end

	// eight bytes or four halfwords per block
	assign blockIndex = use16Bit ? samplePos[11:2] : samplePos[12:3];

	always_ff @(posedge clock)
	begin
		byteSel <= block[{samplePos[2:0], 3'b000} +: 8];
		halfSel <= block[{samplePos[1:0], 4'b0000} +: 16];
	end

	// E3.M4: leading one appears from exponent 1 up
	assign exponent = byteSel[6:4];
	assign mantissa = byteSel[3:0];

	always_comb
	begin
		if (exponent == 3'd0)
			magnitude = {7'd0, mantissa};
		else
			magnitude = {6'd0, 1'b1, mantissa} << (exponent - 3'd1);
	end

	always_ff @(posedge clock)
	begin
		if (byteSel[7])
			companded <= {1'b1, ~magnitude};
		else
			companded <= {1'b0, magnitude};
	end

	// linear formats come in as offset binary, compand 16-bit is signed
	always_comb
	begin
		if (use16Bit)
			sample = {halfSel[15] ^ ~useCompand, halfSel[14:4]};
		else if (useCompand)
			sample = companded;
		else
			sample = {~byteSel[7], byteSel[6:0], 4'h0};
	end

endmodule

// ==== test/pcmAudioDeviceTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the mono PCM sound device
// bus tasks, reference model, random tests and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcmAudioDeviceTb;
	import audioPkg::*;

	localparam logic [4:0] opRead = 5'b01000;
	localparam logic [4:0] opWrite = 5'b10000;
	localparam int ratePeriod = 391;
	localparam int rateSettle = 6300;
	localparam int rateSpan = ratePeriod * 16;
	localparam int decodeSpan = 2048 + 64 + 65536 + 20;
	localparam int beepWindows = 24;
	localparam int maxEdges = 6;
	localparam int beepSpan = beepWindows * 4096 + 64;
	localparam int timeoutCycles = 400 + rateSettle + rateSpan + 4 * decodeSpan + beepSpan + 20000;

	logic clock;
	logic reset;
	logic [31:0] busAddr;
	logic [31:0] busInData;
	logic [4:0] busOpm;
	logic [31:0] busOutData;
	busResp busOK;
	logic tick1MHz;
	logic [1:0] pwmOut;
	logic pwmEna;
	int cycleCount = 0;

	pcmAudioDevice pcmAudioDevice_i
	(
		.clock(clock),
		.reset(reset),
		.busAddr(busAddr),
		.busInData(busInData),
		.busOpm(busOpm),
		.busOutData(busOutData),
		.busOK(busOK),
		.tick1MHz(tick1MHz),
		.pwmOut(pwmOut),
		.pwmEna(pwmEna)
	);

	always #50 clock = ~clock;

	// run limit from the summed test lengths
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(string testName, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", testName, expected, actual);
			$display("Verification failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	// returns the expected value when the actual one is close enough
	function automatic int nearOrActual(int expected, int actual, int tol);
		if (actual - expected <= tol && expected - actual <= tol)
			return expected;
		return actual;
	endfunction

	function automatic logic [31:0] regAddr(logic [5:0] index);
		return {4'h0, deviceSelect, controlPage, 4'h0, index, 2'b00};
	endfunction

	function automatic logic [31:0] memAddr(int index, int bank);
		return {4'h0, deviceSelect, 3'b000, 10'(index), 1'(bank), 2'b00};
	endfunction

	// reference decode of one 8-bit sample
	function automatic logic [11:0] decodeByte(logic [7:0] b, logic compand);
		int mag;
		int e;
		if (!compand)
			return {~b[7], b[6:0], 4'h0};
		e = int'(b[6:4]);
		mag = int'(b[3:0]);
		if (e > 0)
			mag = (mag + 16) << (e - 1);
		if (b[7])
			mag = 2047 - mag;
		return {b[7], 11'(mag)};
	endfunction

	function automatic logic [11:0] decodeHalf(logic [15:0] h, logic compand);
		return compand ? h[15:4] : {~h[15], h[14:4]};
	endfunction

	// signed mix value to unsigned PWM level
	function automatic int saturateLevel(int v);
		if (v > 8191)
			return 65535;
		if (v < -8192)
			return 0;
		return (v + 8192) * 4;
	endfunction

	function automatic int levelFromSample(logic [11:0] s);
		int v;
		v = int'($signed({s, s[11:8]}));
		v = v >>> 2;
		return saturateLevel(v);
	endfunction

	task automatic waitCycles(int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic busWrite(logic [31:0] addr, logic [31:0] data);
		@(negedge clock);
		busAddr = addr;
		busInData = data;
		busOpm = opWrite;
		@(negedge clock);
		busOpm = '0;
		@(negedge clock);
		checkValue("write response", 32'(respOk), 32'(busOK));
	endtask

	task automatic busRead(logic [31:0] addr, output logic [31:0] data);
		@(negedge clock);
		busAddr = addr;
		busOpm = opRead;
		@(negedge clock);
		busOpm = '0;
		@(negedge clock);
		checkValue("read response", 32'(respOk), 32'(busOK));
		data = busOutData;
	endtask

	// back-to-back writes, one per cycle
	task automatic fillMemory(logic [31:0] word);
		for (int i = 0; i < memDepth; i++)
		begin
			for (int bank = 0; bank < 2; bank++)
			begin
				@(negedge clock);
				busAddr = memAddr(i, bank);
				busInData = word;
				busOpm = opWrite;
			end
		end
		@(negedge clock);
		busOpm = '0;
	endtask

	task automatic countOnes(int cycles, output int ones);
		ones = 0;
		repeat (cycles)
		begin
			@(negedge clock);
			if (pwmOut[0])
				ones++;
		end
	endtask

	task automatic resetAndResponse;
		waitCycles(2);
		checkValue("reset pwmEna", 32'd0, 32'(pwmEna));
		checkValue("reset pwmOut", 32'd3, 32'(pwmOut));
		checkValue("reset busOK", 32'(respReady), 32'(busOK));
		@(negedge clock);
		busAddr = regAddr(regCtrl0Index);
		busOpm = opRead;
		@(negedge clock);
		busOpm = '0;
		checkValue("response one cycle", 32'(respReady), 32'(busOK));
		@(negedge clock);
		checkValue("response two cycles", 32'(respOk), 32'(busOK));
		// position register, device select field off by one
		busAddr = 32'h0008F020;
		busOpm = opRead;
		@(negedge clock);
		busOpm = '0;
		@(negedge clock);
		checkValue("unselected busOK", 32'(respReady), 32'(busOK));
		checkValue("unselected data", 32'd0, busOutData);
	endtask

	task automatic registerReadback;
		logic [31:0] value;
		logic [31:0] readBack;
		repeat (8)
		begin
			value = $urandom();
			busWrite(regAddr(regCtrl1Index), value);
			busRead(regAddr(regCtrl1Index), readBack);
			checkValue("ctrl1 readback", value, readBack);
			value = $urandom() & ~32'h8;
			busWrite(regAddr(regCtrl0Index), value);
			busRead(regAddr(regCtrl0Index), readBack);
			checkValue("ctrl0 readback", value, readBack);
		end
		busWrite(regAddr(regCtrl1Index), 32'd0);
		busWrite(regAddr(regCtrl0Index), 32'd0);
	endtask

	task automatic sampleRate;
		logic [31:0] p1;
		logic [31:0] p2;
		int c1;
		int c2;
		int expected;
		// rate 8, output on; old divider count must run out first
		busWrite(regAddr(regCtrl0Index), 32'h88);
		waitCycles(rateSettle);
		busRead(regAddr(regPositionIndex), p1);
		c1 = cycleCount;
		waitCycles(rateSpan);
		busRead(regAddr(regPositionIndex), p2);
		c2 = cycleCount;
		expected = (c2 - c1) / ratePeriod;
		checkValue("sample rate", expected, nearOrActual(expected, int'((p2 - p1) & 32'h1FFF), 1));
	endtask

	task automatic decodeFormat(int fmt);
		logic [7:0] b;
		logic [15:0] h;
		logic [11:0] s;
		int level;
		int ones;
		b = 8'($urandom());
		h = 16'($urandom());
		if (fmt < 2)
		begin
			fillMemory({4{b}});
			s = decodeByte(b, fmt[0]);
		end
		else
		begin
			fillMemory({2{h}});
			s = decodeHalf(h, fmt[0]);
		end
		// bit 1 picks 16-bit, bit 0 compand
		busWrite(regAddr(regCtrl0Index), 32'h88 | 32'(fmt));
		waitCycles(64);
		checkValue("pwmEna enabled", 32'd1, 32'(pwmEna));
		level = levelFromSample(s);
		countOnes(65536, ones);
		checkValue($sformatf("decode format %0d", fmt), level, nearOrActual(level, ones, 2));
	endtask

	task automatic beeperWindows;
		int ones;
		int highCount;
		int lowCount;
		int edgeCount;
		int highExpect;
		int lowExpect;
		highCount = 0;
		lowCount = 0;
		edgeCount = 0;
		// density per 4096 cycles is level / 16
		highExpect = saturateLevel(int'($signed(beepHigh))) / 16;
		lowExpect = saturateLevel(int'($signed(beepLow))) / 16;
		busWrite(regAddr(regCtrl0Index), 32'h88);
		busWrite(regAddr(regCtrl1Index), 32'd20000);
		@(negedge clock);
		tick1MHz = 1'b1;
		waitCycles(32);
		for (int w = 0; w < beepWindows; w++)
		begin
			countOnes(4096, ones);
			if (nearOrActual(highExpect, ones, 4) == highExpect)
				highCount++;
			else if (nearOrActual(lowExpect, ones, 4) == lowExpect)
				lowCount++;
			else
				edgeCount++;
		end
		checkValue("beep high seen", 32'd1, 32'(highCount > 0));
		checkValue("beep low seen", 32'd1, 32'(lowCount > 0));
		// only windows across a toggle may miss both levels
		checkValue("beep edge windows", 32'd0, nearOrActual(0, edgeCount, maxEdges));
	endtask

	initial
	begin
		void'($urandom(32'he121));
		clock = 1'b0;
		reset = 1'b1;
		busAddr = '0;
		busInData = '0;
		busOpm = '0;
		tick1MHz = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		resetAndResponse();
		registerReadback();
		sampleRate();
		for (int fmt = 0; fmt < 4; fmt++)
			decodeFormat(fmt);
		beeperWindows();
		$display("Verification passed");
		$finish;
	end

endmodule
